/* cic_pkg.sv */
package cic_pkg;

    // datapath widths
    localparam int SAMPLE_W = 5;                // input sample, signed
    localparam int ACC_W    = 13;               // holds the frame sum for DECIM up to 256
    localparam int COEF_W   = 13;               // gain correction coefficient
    localparam int PROD_W   = 48;               // full width of the P output

    // operand widths inside the multiplier, as the DSP48 ports
    localparam int MULT_A_W = 30;
    localparam int MULT_B_W = 18;

    // clocks from multiplier input to p
    // two operand stages, one product stage, one output stage
    localparam int MULT_LATENCY = 4;

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // raw input sample
    typedef logic signed [ACC_W-1:0]    acc_t;      // accumulator and decimated sum
    typedef logic signed [COEF_W-1:0]   coef_t;     // correction coefficient
    typedef logic signed [PROD_W-1:0]   prod_t;     // corrected output

    typedef logic signed [MULT_A_W-1:0] mult_a_t;   // sign extended a operand
    typedef logic signed [MULT_B_W-1:0] mult_b_t;   // sign extended b operand

endpackage

/* cic_ctrl_pkg.sv */
package cic_ctrl_pkg;

    // decimation counter, counts 0 .. DECIM-1
    localparam int CNT_W = 8;

    typedef logic [CNT_W-1:0] cnt_t;

    // output handshake states
    typedef enum logic [1:0] {
        IDLE,               // no request pending, ready to take a product
        REQ_HIGH,           // out_req up, waiting for the consumer to ack
        ACK_WAIT_LOW        // out_req dropped, waiting for out_ack to fall
    } ctrl_state_t;

endpackage

/* cic_integrator.sv */
`timescale 1ns/1ps

module cic_integrator (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_en,         // one-cycle strobe per input sample
    input  cic_pkg::sample_t in_sample,
    output cic_pkg::acc_t    acc            // running sum, wraps modulo 2^13
);

    cic_pkg::acc_t acc_r;
    cic_pkg::acc_t sample_ext;

    // sign extension of the 5-bit sample up to accumulator width
    assign sample_ext = cic_pkg::acc_t'(in_sample);

    // the integrator is free to overflow
    // the comb difference at dump time undoes the wrap exactly
    always_ff @(posedge clk) begin
        if (reset) begin
            acc_r <= '0;                        // start from an empty sum
        end else if (in_en) begin
            acc_r <= acc_r + sample_ext;        // add on the accepting edge
        end
    end

    assign acc = acc_r;

endmodule

/* cic_comb.sv */
`timescale 1ns/1ps

module cic_comb (
    input  logic          clk,
    input  logic          reset,
    input  cic_pkg::acc_t acc,              // integrator output
    input  logic          dump,             // one-cycle pulse after the last sample
    output cic_pkg::acc_t comb_out,         // frame sum, exact for DECIM up to 256
    output logic          comb_valid        // high the cycle after dump
);

    cic_pkg::acc_t prev_acc;                // acc seen at the previous dump
    cic_pkg::acc_t comb_r;
    logic          valid_r;

    // control and the stored value get a reset
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_acc <= '0;                 // matches the cleared integrator
            valid_r  <= 1'b0;
        end else begin
            valid_r <= dump;
            if (dump) begin
                prev_acc <= acc;            // remember for the next frame
            end
        end
    end

    // difference wraps modulo 2^13 like the integrator
    always_ff @(posedge clk) begin
        if (dump) begin
            comb_r <= acc - prev_acc;
        end
    end

    assign comb_out   = comb_r;
    assign comb_valid = valid_r;

    // frames are at least two samples long, so results never come back to back
    a_no_back_to_back : assert property (
        @(posedge clk) disable iff (reset)
        comb_valid |=> !comb_valid
    ) else $error("comb_valid high on two consecutive cycles");

endmodule

/* dsp48_cic_M256_N1_R1_iw5_0_corr.sv */
`timescale 1ns/1ps

// portable model of the DSP48 gain correction multiplier
// AREG=2, BREG=2, MREG=1, PREG=1, so four clocks from a/b to p
module dsp48_cic_M256_N1_R1_iw5_0_corr (
    input  logic           clk,
    input  logic [12:0]    a,               // decimated sum
    input  logic [12:0]    b,               // correction coefficient
    output cic_pkg::prod_t p
);

    cic_pkg::mult_a_t a_s;                  // a widened to the A port
    cic_pkg::mult_b_t b_s;                  // b widened to the B port

    cic_pkg::mult_a_t a1_r;                 // first A stage
    cic_pkg::mult_a_t a2_r;                 // second A stage
    cic_pkg::mult_b_t b1_r;                 // first B stage
    cic_pkg::mult_b_t b2_r;                 // second B stage
    cic_pkg::prod_t   m_r;                  // multiplier register
    cic_pkg::prod_t   p_r;                  // output register

    // replicate the sign bit, as on the primitive ports
    assign a_s = {{17{a[12]}}, a};
    assign b_s = {{5{b[12]}}, b};

    // operand pipeline, two deep on both ports
    always_ff @(posedge clk) begin
        a1_r <= a_s;
        a2_r <= a1_r;
        b1_r <= b_s;
        b2_r <= b1_r;
    end

    // signed 30x18 product fits 48 bits, then the P register
    // no reset here, the primitive runs with all RST pins tied low
    always_ff @(posedge clk) begin
        m_r <= a2_r * b2_r;
        p_r <= m_r;                         // opmode passes M straight to P
    end

    assign p = p_r;

endmodule

/* cic_ctrl.sv */
`timescale 1ns/1ps

module cic_ctrl #(
    parameter int DECIM = 256               // decimation ratio, 2 .. 256
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           in_en,           // sample strobe, same as the integrator's
    output logic           dump,            // one-cycle pulse, frame complete
    input  logic           comb_valid,      // comb result entering the multiplier
    input  cic_pkg::prod_t p,               // multiplier output
    input  logic           out_ack,
    output logic           out_req,
    output cic_pkg::prod_t out_data,
    output logic           overrun          // sticky, a product was dropped
);

    localparam int LAT = cic_pkg::MULT_LATENCY;

    // counter value when the DECIM-th sample is accepted
    localparam cic_ctrl_pkg::cnt_t LAST_CNT = cic_ctrl_pkg::cnt_t'(DECIM - 1);
    localparam cic_ctrl_pkg::cnt_t CNT_ONE  = cic_ctrl_pkg::cnt_t'(1);

    cic_ctrl_pkg::cnt_t        cnt;         // accepted samples in this frame
    logic                      dump_r;
    logic [LAT-1:0]            vld_sr;      // one bit per frame in the multiplier
    logic                      p_valid;     // p holds a fresh product this cycle
    cic_ctrl_pkg::ctrl_state_t state;
    logic                      req_r;
    logic                      ovr_r;
    cic_pkg::prod_t            data_r;

    // decimation count, dump is registered so it lands the cycle after edge t
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= '0;
            dump_r <= 1'b0;
        end else begin
            dump_r <= 1'b0;                 // pulse by default
            if (in_en) begin
                if (cnt == LAST_CNT) begin
                    cnt    <= '0;           // start next frame
                    dump_r <= 1'b1;
                end else begin
                    cnt <= cnt + CNT_ONE;
                end
            end
        end
    end

    assign dump = dump_r;

    // follows comb_valid down the multiplier pipeline
    // several frames may be in flight at once when DECIM is small
    always_ff @(posedge clk) begin
        if (reset) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT-2:0], comb_valid};
        end
    end

    assign p_valid = vld_sr[LAT-1];         // aligned with p

    // four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cic_ctrl_pkg::IDLE;
            req_r <= 1'b0;
            ovr_r <= 1'b0;
        end else begin
            case (state)
                cic_ctrl_pkg::IDLE: begin
                    if (p_valid) begin
                        req_r <= 1'b1;      // data captured on the same edge
                        state <= cic_ctrl_pkg::REQ_HIGH;
                    end
                end
                cic_ctrl_pkg::REQ_HIGH: begin
                    if (out_ack) begin
                        req_r <= 1'b0;      // consumer has the data
                        state <= cic_ctrl_pkg::ACK_WAIT_LOW;
                    end
                end
                cic_ctrl_pkg::ACK_WAIT_LOW: begin
                    if (!out_ack) begin
                        state <= cic_ctrl_pkg::IDLE;    // cycle complete
                    end
                end
                default: begin
                    state <= cic_ctrl_pkg::IDLE;
                    req_r <= 1'b0;
                end
            endcase
            // product with nowhere to go is lost
            if (p_valid && state != cic_ctrl_pkg::IDLE) begin
                ovr_r <= 1'b1;              // held until reset
            end
        end
    end

    // output payload, only loaded when a new request starts
    always_ff @(posedge clk) begin
        if (state == cic_ctrl_pkg::IDLE && p_valid) begin
            data_r <= p;
        end
    end

    assign out_req  = req_r;
    assign out_data = data_r;
    assign overrun  = ovr_r;

    // request is only withdrawn after the consumer acks
    a_req_hold : assert property (
        @(posedge clk) disable iff (reset)
        (out_req && !out_ack) |=> out_req
    ) else $error("out_req dropped without out_ack");

    // payload frozen for the whole request, even when products are dropped
    a_data_stable : assert property (
        @(posedge clk) disable iff (reset)
        (out_req && $past(out_req)) |-> $stable(out_data)
    ) else $error("out_data changed while out_req high");

endmodule

/* cic_decim_top.sv */
`timescale 1ns/1ps

module cic_decim_top #(
    parameter int DECIM = 256               // decimation ratio, 2 .. 256
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_en,         // one strobe per sample
    input  cic_pkg::sample_t in_sample,
    input  cic_pkg::coef_t   corr_coef,     // static while running
    input  logic             out_ack,
    output logic             out_req,
    output cic_pkg::prod_t   out_data,
    output logic             overrun
);

    cic_pkg::acc_t  acc;                    // integrator to comb
    logic           dump;                   // frame boundary from control
    cic_pkg::acc_t  comb_out;               // decimated sum
    logic           comb_valid;
    cic_pkg::prod_t p;                      // corrected product

    // integrator
    cic_integrator u_integrator (
        .clk       (clk),
        .reset     (reset),
        .in_en     (in_en),
        .in_sample (in_sample),
        .acc       (acc)
    );

    // comb, runs at the decimated rate
    cic_comb u_comb (
        .clk        (clk),
        .reset      (reset),
        .acc        (acc),
        .dump       (dump),
        .comb_out   (comb_out),
        .comb_valid (comb_valid)
    );

    // gain correction
    dsp48_cic_M256_N1_R1_iw5_0_corr u_corr (
        .clk (clk),
        .a   (comb_out),
        .b   (corr_coef),
        .p   (p)
    );

    // decimation count, latency tracking and output handshake
    cic_ctrl #(
        .DECIM (DECIM)
    ) u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .in_en      (in_en),
        .dump       (dump),
        .comb_valid (comb_valid),
        .p          (p),
        .out_ack    (out_ack),
        .out_req    (out_req),
        .out_data   (out_data),
        .overrun    (overrun)
    );

endmodule

/* tb_cic_decim.sv */
`timescale 1ns/1ps

module tb_cic_decim;

    localparam int DECIM       = 16;        // short frames keep the run quick
    localparam int REQ_EDGE    = 6;         // edges from last accepted sample to out_req set
    localparam int PATH_CLKS   = 7;         // out_req first sampled high this many edges later
    localparam int ST_IDLE     = 0;         // handshake idle and able to take a product
    localparam int ST_REQ      = 1;         // request up with no ack yet
    localparam int ST_WAIT     = 2;         // request down while ack is still high
    localparam int MODE_RANDOM = 0;
    localparam int MODE_MIN    = 1;         // every sample at -16
    localparam int MODE_MAX    = 2;         // every sample at +15

    logic             clk;
    logic             reset;
    logic             in_en;
    cic_pkg::sample_t in_sample;
    cic_pkg::coef_t   corr_coef;
    logic             out_ack;
    logic             out_req;
    cic_pkg::prod_t   out_data;
    logic             overrun;

    logic           hold_ack;               // consumer stall forcing back-pressure
    int             max_delay;              // longest ack delay in clocks
    logic           req_pending;            // consumer has seen the request
    int             ack_wait;               // clocks left before the ack
    int             frames_driven;

    // reference model state updated on the rising edge from sampled ports
    int             cyc;
    int             acc_cnt;                // samples accepted in the current frame
    int             frame_sum;
    int             model_st;
    logic           ovr_pred;               // overrun the DUT must show
    logic           any_arrival;
    logic           prev_req;
    logic           prev_ack;
    cic_pkg::prod_t prev_data;
    cic_pkg::prod_t pend_data_q[$];         // products still inside the pipeline
    int             pend_cyc_q[$];          // edge where each reaches the handshake
    cic_pkg::prod_t exp_data_q[$];          // products that must be presented
    int             exp_cyc_q[$];           // sampling edge of the matching out_req rise
    int             rises;

    cic_decim_top #(
        .DECIM (DECIM)
    ) u_dut (
        .clk       (clk),
        .reset     (reset),
        .in_en     (in_en),
        .in_sample (in_sample),
        .corr_coef (corr_coef),
        .out_ack   (out_ack),
        .out_req   (out_req),
        .out_data  (out_data),
        .overrun   (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopping at the first error");
    endtask

    // frame sum times coefficient at the full 48-bit product width
    function automatic cic_pkg::prod_t corrected(input int sum, input cic_pkg::coef_t coef);
        longint full;
        full = longint'(sum) * longint'(coef);
        return cic_pkg::prod_t'(full);
    endfunction

    // reference model and port checks
    always @(posedge clk) begin
        logic           arrive;
        cic_pkg::prod_t head_data;
        int             head_cyc;
        cyc    = cyc + 1;
        arrive = 1'b0;
        if (reset) begin
            acc_cnt     = 0;
            frame_sum   = 0;
            model_st    = ST_IDLE;
            ovr_pred    = 1'b0;
            any_arrival = 1'b0;
            prev_req    = 1'b0;
            prev_ack    = 1'b0;
            pend_data_q.delete();
            pend_cyc_q.delete();
            exp_data_q.delete();
            exp_cyc_q.delete();
        end else begin
            if (!any_arrival) begin         // nothing may show before the first frame
                assert (!out_req && !overrun)
                    else report_failure("out_req or overrun set before any frame completed");
            end
            assert (overrun == ovr_pred)
                else report_failure($sformatf("mismatch at %0t: overrun got %0b expected %0b",
                                              $time, overrun, ovr_pred));
            assert (out_req == (model_st == ST_REQ))
                else report_failure($sformatf("mismatch at %0t: out_req got %0b expected %0b",
                                              $time, out_req, model_st == ST_REQ));
            if (prev_req && !prev_ack) begin
                assert (out_req) else report_failure("out_req fell before out_ack rose");
            end
            if (out_req && !prev_req) begin
                assert (!prev_ack) else report_failure("out_req rose while out_ack was high");
                assert (exp_data_q.size() > 0)
                    else report_failure("out_req rose with no result expected");
                head_data = exp_data_q.pop_front();
                head_cyc  = exp_cyc_q.pop_front();
                assert (out_data == head_data)
                    else report_failure($sformatf("mismatch at %0t: out_data got %0d expected %0d",
                                                  $time, out_data, head_data));
                assert (cyc == head_cyc)
                    else report_failure($sformatf("out_req rose %0d clocks off the fixed latency",
                                                  cyc - head_cyc));
                rises = rises + 1;
            end
            if (out_req && prev_req) begin  // payload frozen during the request
                assert (out_data == prev_data)
                    else report_failure($sformatf("mismatch at %0t: out_data got %0d expected %0d",
                                                  $time, out_data, prev_data));
            end
            if (in_en) begin
                frame_sum = frame_sum + int'(in_sample);
                acc_cnt   = acc_cnt + 1;
                if (acc_cnt == DECIM) begin // last sample of the frame taken here
                    pend_data_q.push_back(corrected(frame_sum, corr_coef));
                    pend_cyc_q.push_back(cyc + REQ_EDGE);
                    acc_cnt   = 0;
                    frame_sum = 0;
                end
            end
            if (pend_cyc_q.size() > 0 && pend_cyc_q[0] == cyc) begin
                arrive      = 1'b1;
                any_arrival = 1'b1;
                head_data   = pend_data_q.pop_front();
                head_cyc    = pend_cyc_q.pop_front();
            end
            case (model_st)
                ST_IDLE: begin
                    if (arrive) begin
                        exp_data_q.push_back(head_data);
                        exp_cyc_q.push_back(head_cyc + PATH_CLKS - REQ_EDGE);
                        model_st = ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (arrive) begin
                        ovr_pred = 1'b1;    // busy so the product is lost
                    end
                    if (out_ack) begin
                        model_st = ST_WAIT;
                    end
                end
                default: begin
                    if (arrive) begin
                        ovr_pred = 1'b1;
                    end
                    if (!out_ack) begin
                        model_st = ST_IDLE;
                    end
                end
            endcase
            prev_req  = out_req;
            prev_ack  = out_ack;
            prev_data = out_data;
        end
    end

    // consumer side of the four-phase handshake
    always @(posedge clk) begin
        if (reset) begin
            out_ack     <= 1'b0;
            req_pending = 1'b0;
            ack_wait    = 0;
        end else if (out_ack) begin
            if (!out_req) begin
                out_ack <= 1'b0;            // release once the request is gone
            end
        end else if (out_req && !hold_ack) begin
            if (!req_pending) begin
                req_pending = 1'b1;
                ack_wait    = $urandom_range(max_delay, 0);
            end
            if (ack_wait == 0) begin
                out_ack     <= 1'b1;
                req_pending = 1'b0;
            end else begin
                ack_wait = ack_wait - 1;
            end
        end
    end

    task automatic drive_frames(input int frames, input int mode);
        int left;
        int guard;
        left          = frames * DECIM;
        guard         = 0;
        frames_driven = frames_driven + frames;
        while (left > 0) begin
            @(posedge clk);
            guard = guard + 1;
            if (guard > frames * DECIM * 20) begin
                report_failure("timeout while driving input samples");
            end
            if ($urandom_range(2, 0) != 0) begin
                in_en <= 1'b1;
                left  = left - 1;
                if (mode == MODE_MIN) begin
                    in_sample <= cic_pkg::sample_t'(-16);
                end else if (mode == MODE_MAX) begin
                    in_sample <= cic_pkg::sample_t'(15);
                end else begin
                    in_sample <= cic_pkg::sample_t'($urandom_range(31, 0));
                end
            end else begin
                in_en     <= 1'b0;
                in_sample <= cic_pkg::sample_t'($urandom_range(31, 0));     // ignored
            end
        end
        @(posedge clk);
        in_en <= 1'b0;
    endtask

    // pipeline empty and handshake back in idle
    task automatic wait_quiet(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (pend_cyc_q.size() > 0 || model_st != ST_IDLE || out_ack) begin
            @(negedge clk);
            n = n + 1;
            if (n > limit) begin
                report_failure("timeout waiting for the output handshake to go idle");
            end
        end
    endtask

    task automatic wait_overrun(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!overrun) begin
            @(negedge clk);
            n = n + 1;
            if (n > limit) begin
                report_failure("timeout waiting for overrun to rise");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h68cd));
        reset         = 1'b1;
        in_en         = 1'b0;
        in_sample     = '0;
        corr_coef     = cic_pkg::coef_t'(1234);  // positive phase
        out_ack       = 1'b0;
        hold_ack      = 1'b0;
        max_delay     = 5;
        frames_driven = 0;
        cyc           = 0;
        rises         = 0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        drive_frames(6, MODE_RANDOM);
        wait_quiet(200);
        @(posedge clk);
        corr_coef <= cic_pkg::coef_t'(-777);     // negative phase
        drive_frames(6, MODE_RANDOM);
        wait_quiet(200);
        @(posedge clk);
        corr_coef <= cic_pkg::coef_t'(-4096);    // largest magnitude
        drive_frames(3, MODE_RANDOM);
        drive_frames(2, MODE_MIN);                // sum -256
        drive_frames(2, MODE_MAX);                // sum +240
        wait_quiet(200);
        @(posedge clk);
        max_delay <= 0;                           // quick acks for the latency check
        corr_coef <= cic_pkg::coef_t'(1234);
        drive_frames(4, MODE_RANDOM);
        wait_quiet(200);
        @(posedge clk);
        hold_ack <= 1'b1;                         // first frame waits and the next two are dropped
        drive_frames(3, MODE_RANDOM);
        wait_overrun(200);
        repeat (10) @(posedge clk);
        hold_ack <= 1'b0;
        wait_quiet(200);
        @(posedge clk);
        max_delay <= 5;
        drive_frames(2, MODE_RANDOM);             // overrun must stay high here
        wait_quiet(200);
        @(negedge clk);
        assert (overrun) else report_failure("overrun did not stay set until the end");
        assert (exp_data_q.size() == 0) else report_failure("expected results never presented");
        assert (rises == frames_driven - 2)
            else report_failure($sformatf("mismatch at %0t: rises got %0d expected %0d",
                                          $time, rises, frames_driven - 2));
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* cic_decim.f */
cic_pkg.sv
cic_ctrl_pkg.sv
cic_integrator.sv
cic_comb.sv
dsp48_cic_M256_N1_R1_iw5_0_corr.sv
cic_ctrl.sv
cic_decim_top.sv
tb_cic_decim.sv

/* run.sh */
#!/bin/sh
# build and run the cic_decim testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_cic_decim \
    -f cic_decim.f

# the simulator exits non-zero on failure, the pass line decides the result
out=$(./obj_dir/Vtb_cic_decim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "=== PASS ==="; then
    exit 0
else
    exit 1
fi
